// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module conv_1x1_tb -o conv_1x1_sim
	./obj_dir/conv_1x1_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
rtl/conv_geom_pkg.sv
rtl/conv_data_pkg.sv
rtl/fifo_if.sv
rtl/cnn_fifo_delay.sv
rtl/conv_1x1_buffer_weights.sv
rtl/conv_1x1_weight_bank.sv
rtl/conv_1x1_engine.sv
rtl/conv_1x1_top.sv
tests/conv_1x1_props.sv
tests/conv_1x1_tb.sv

// File: rtl/cnn_fifo_delay.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_fifo_delay #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = 4
) (
	input  logic clk,
	input  logic reset,
	fifo_if.fifo q
);

	// Pointer width, at least one bit
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Storage
	item_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Occupancy, one bit wider than a pointer
	logic [PTR_W:0]   count;

	logic do_write;
	logic do_read;

	// Writes into a full FIFO are dropped
	assign do_write = q.write && !q.full;
	// Reads of an empty FIFO do nothing
	assign do_read  = q.read && !q.empty;

	// Status straight from the count
	assign q.full  = (count == (PTR_W+1)'(DEPTH));
	assign q.empty = (count == '0);

	// Show-ahead output
	assign q.rdata = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Storage write
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= q.wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers and count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Explicit wrap, depth need not be a power of two
			if (do_write) begin
				if (wr_ptr == PTR_W'(DEPTH-1)) wr_ptr <= '0;
				else wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				if (rd_ptr == PTR_W'(DEPTH-1)) rd_ptr <= '0;
				else rd_ptr <= rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/conv_1x1_buffer_weights.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_buffer_weights (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 weight_valid,
	input  conv_data_pkg::data_t weight,
	input  logic                 load_weights,
	output conv_data_pkg::data_t weight_head,
	output logic                 weight_avail
);

	// Input register stage
	conv_data_pkg::data_t weight_q;
	logic                 weight_valid_q;

	// Link from the input register to the weight FIFO
	fifo_if #(.item_t(conv_data_pkg::data_t)) wq ();

	////////////////////////////////////////////////////////////////////////////
	// Input register
	////////////////////////////////////////////////////////////////////////////

	// Data word follows the input on every edge
	always_ff @(posedge clk) begin
		weight_q <= weight;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			weight_valid_q <= 1'b0;
		end else begin
			weight_valid_q <= weight_valid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Weight FIFO of one full set
	////////////////////////////////////////////////////////////////////////////

	assign wq.write = weight_valid_q;
	assign wq.wdata = weight_q;
	// One pop per bank strobe
	assign wq.read  = load_weights;

	cnn_fifo_delay #(
		.item_t(conv_data_pkg::data_t),
		.DEPTH (conv_geom_pkg::WEIGHT_NUM)
	) u_weight_fifo (
		.clk  (clk),
		.reset(reset),
		.q    (wq)
	);

	// Head word and its presence go to the bank
	assign weight_head  = wq.rdata;
	assign weight_avail = !wq.empty;

endmodule

`default_nettype wire

// File: rtl/conv_1x1_engine.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_engine (
	input  logic                    clk,
	input  logic                    reset,
	fifo_if.consumer                pix,
	input  conv_data_pkg::weights_t weight_set,
	input  logic                    weights_ready,
	output logic                    result_valid,
	output conv_data_pkg::result_t  result
);

	// Head pixel of the FIFO
	conv_data_pkg::pixel_t px;

	// Pop strobe, one pixel per cycle
	logic pop;

	// Stage one products, index o*IN_CH+i
	conv_data_pkg::acc_t prod_q [conv_geom_pkg::WEIGHT_NUM];
	logic                s1_valid;

	// Stage two sums before the register
	conv_data_pkg::result_t sum_d;

	assign px = pix.rdata;

	// Nothing moves until the full weight set is in
	assign pop      = weights_ready && !pix.empty;
	assign pix.read = pop;

	////////////////////////////////////////////////////////////////////////////
	// Stage one: products
	////////////////////////////////////////////////////////////////////////////

	// Both operands sign-extended to the accumulator width
	always_ff @(posedge clk) begin
		if (pop) begin
			for (int o = 0; o < conv_geom_pkg::OUT_CH; o++) begin
				for (int i = 0; i < conv_geom_pkg::IN_CH; i++) begin
					prod_q[o*conv_geom_pkg::IN_CH + i] <=
						conv_data_pkg::acc_t'(px[i]) *
						conv_data_pkg::acc_t'(weight_set[o*conv_geom_pkg::IN_CH + i]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= pop;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage two: per-output sums
	////////////////////////////////////////////////////////////////////////////

	// Sum over inputs, wraps at ACC_WIDTH
	always_comb begin
		for (int o = 0; o < conv_geom_pkg::OUT_CH; o++) begin
			sum_d[o] = '0;
			for (int i = 0; i < conv_geom_pkg::IN_CH; i++) begin
				sum_d[o] = sum_d[o] + prod_q[o*conv_geom_pkg::IN_CH + i];
			end
		end
	end

	// Products hold between pops, so only the valid bit gates
	always_ff @(posedge clk) begin
		if (s1_valid) begin
			result <= sum_d;
		end
	end

	// Two cycles from pop to result
	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

// File: rtl/conv_1x1_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_top #(
	parameter int PIXEL_DEPTH = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   weight_valid,
	input  conv_data_pkg::data_t   weight,
	input  logic                   pixel_valid,
	input  conv_data_pkg::pixel_t  pixel,
	output logic                   weights_ready,
	output logic                   pixel_full,
	output logic                   result_valid,
	output conv_data_pkg::result_t result
);

	// Buffer to bank
	conv_data_pkg::data_t    weight_head;
	logic                    weight_avail;
	logic                    load_weights;

	// Bank to engine
	conv_data_pkg::weights_t weight_set;

	// Pixel queue between the ports and the engine
	fifo_if #(.item_t(conv_data_pkg::pixel_t)) pix_q ();

	////////////////////////////////////////////////////////////////////////////
	// Weight path
	////////////////////////////////////////////////////////////////////////////

	conv_1x1_buffer_weights u_buffer (
		.clk         (clk),
		.reset       (reset),
		.weight_valid(weight_valid),
		.weight      (weight),
		.load_weights(load_weights),
		.weight_head (weight_head),
		.weight_avail(weight_avail)
	);

	conv_1x1_weight_bank u_bank (
		.clk          (clk),
		.reset        (reset),
		.weight_head  (weight_head),
		.weight_avail (weight_avail),
		.load_weights (load_weights),
		.weight_set   (weight_set),
		.weights_ready(weights_ready)
	);

	////////////////////////////////////////////////////////////////////////////
	// Pixel path
	////////////////////////////////////////////////////////////////////////////

	assign pix_q.write = pixel_valid;
	assign pix_q.wdata = pixel;
	// Only input back-pressure
	assign pixel_full  = pix_q.full;

	cnn_fifo_delay #(
		.item_t(conv_data_pkg::pixel_t),
		.DEPTH (PIXEL_DEPTH)
	) u_pixel_fifo (
		.clk  (clk),
		.reset(reset),
		.q    (pix_q)
	);

	conv_1x1_engine u_engine (
		.clk          (clk),
		.reset        (reset),
		.pix          (pix_q),
		.weight_set   (weight_set),
		.weights_ready(weights_ready),
		.result_valid (result_valid),
		.result       (result)
	);

endmodule

`default_nettype wire

// File: rtl/conv_1x1_weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_weight_bank (
	input  logic                    clk,
	input  logic                    reset,
	input  conv_data_pkg::data_t    weight_head,
	input  logic                    weight_avail,
	output logic                    load_weights,
	output conv_data_pkg::weights_t weight_set,
	output logic                    weights_ready
);

	// Slot index width
	localparam int IDX_W = (conv_geom_pkg::WEIGHT_NUM > 1) ?
		$clog2(conv_geom_pkg::WEIGHT_NUM) : 1;

	// Slot that takes the next popped word
	logic [IDX_W-1:0] idx;
	logic             last_slot;

	// Drain whenever the buffer holds a word
	assign load_weights = weight_avail;

	assign last_slot = (idx == IDX_W'(conv_geom_pkg::WEIGHT_NUM - 1));

	////////////////////////////////////////////////////////////////////////////
	// Slot registers
	////////////////////////////////////////////////////////////////////////////

	// Arrival order: slot 0 first
	// A later set overwrites in the same order
	always_ff @(posedge clk) begin
		if (load_weights) begin
			weight_set[idx] <= weight_head;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Index and ready flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			idx <= '0;
		end else if (load_weights) begin
			// Wrap after the last slot
			if (last_slot) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// Set on the edge that stores the last slot
	// Held until reset, also across reloads
	always_ff @(posedge clk) begin
		if (reset) begin
			weights_ready <= 1'b0;
		end else if (load_weights && last_slot) begin
			weights_ready <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/conv_data_pkg.sv
`default_nettype none

package conv_data_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Scalar words
	////////////////////////////////////////////////////////////////////////////

	// Weight or channel value
	typedef logic signed [conv_geom_pkg::DATA_WIDTH-1:0] data_t;

	// One output channel value
	typedef logic signed [conv_geom_pkg::ACC_WIDTH-1:0] acc_t;

	////////////////////////////////////////////////////////////////////////////
	// Grouped payloads
	////////////////////////////////////////////////////////////////////////////

	// Element i is input channel i
	typedef data_t [conv_geom_pkg::IN_CH-1:0] pixel_t;

	// Element o*IN_CH+i is the weight from input i to output o
	typedef data_t [conv_geom_pkg::WEIGHT_NUM-1:0] weights_t;

	// Element o is output channel o
	typedef acc_t [conv_geom_pkg::OUT_CH-1:0] result_t;

endpackage

`default_nettype wire

// File: rtl/conv_geom_pkg.sv
`default_nettype none

package conv_geom_pkg;

	// Channel counts of the 1x1 stage
	localparam int IN_CH  = 2;
	localparam int OUT_CH = 2;

	// One weight per input and output channel pair
	localparam int WEIGHT_NUM = OUT_CH * IN_CH;

	// Pixel value and weight width
	localparam int DATA_WIDTH = 16;

	// Output width; sums wrap modulo 2**ACC_WIDTH
	localparam int ACC_WIDTH = 32;

endpackage

`default_nettype wire

// File: rtl/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
	parameter type item_t = logic [7:0]
);

	// Producer side
	logic  write;
	item_t wdata;

	// Consumer side, rdata shows the head item
	logic  read;
	item_t rdata;

	// Status from the FIFO
	logic  full;
	logic  empty;

	modport producer (output write, output wdata, input full);

	modport consumer (output read, input rdata, input empty);

	modport fifo (
		input  write,
		input  wdata,
		input  read,
		output rdata,
		output full,
		output empty
	);

endinterface

`default_nettype wire

// File: tests/conv_1x1_props.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_props (
	input logic clk,
	input logic reset,
	input logic weights_ready,
	input logic result_valid,
	input logic fifo_full,
	input logic fifo_empty
);

	// No result without a complete weight set
	a_valid_needs_weights: assert property (
		@(posedge clk) disable iff (reset) result_valid |-> weights_ready
	) else $error("result_valid high while weights_ready is low");

	// Pixel FIFO status is exclusive
	a_full_or_empty: assert property (
		@(posedge clk) disable iff (reset) !(fifo_full && fifo_empty)
	) else $error("pixel FIFO reports full and empty together");

	// Clean outputs right after reset
	a_reset_clears: assert property (
		@(posedge clk) reset |=> (!result_valid && !weights_ready)
	) else $error("result_valid or weights_ready high after reset");

endmodule

// Attach to every conv_1x1_top
bind conv_1x1_top conv_1x1_props u_props (
	.clk          (clk),
	.reset        (reset),
	.weights_ready(weights_ready),
	.result_valid (result_valid),
	.fifo_full    (pix_q.full),
	.fifo_empty   (pix_q.empty)
);

`default_nettype wire

// File: tests/conv_1x1_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_1x1_tb;

	localparam int PIXEL_DEPTH = 8;
	localparam int TIMEOUT = 200;

	logic clk;
	logic reset;
	logic weight_valid;
	conv_data_pkg::data_t weight;
	logic pixel_valid;
	conv_data_pkg::pixel_t pixel;
	logic weights_ready;
	logic pixel_full;
	logic result_valid;
	conv_data_pkg::result_t result;

	// Model state: weights in arrival order, accepted pixels awaiting results
	conv_data_pkg::data_t model_w [conv_geom_pkg::WEIGHT_NUM];
	int model_idx;
	conv_data_pkg::pixel_t pending [$];

	logic [31:0] lcg_state;
	string cur_test;
	int value_errors;
	int other_errors;
	int results_seen;
	int accepted;
	int base;
	int gap;

	conv_1x1_top #(.PIXEL_DEPTH(PIXEL_DEPTH)) UUT (
		.clk          (clk),
		.reset        (reset),
		.weight_valid (weight_valid),
		.weight       (weight),
		.pixel_valid  (pixel_valid),
		.pixel        (pixel),
		.weights_ready(weights_ready),
		.pixel_full   (pixel_full),
		.result_valid (result_valid),
		.result       (result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Classic LCG, upper half is the better-mixed part
	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	// Output o = sum over i of w[o*IN_CH+i] * p[i], kept mod 2**32
	function automatic conv_data_pkg::result_t expected_result(conv_data_pkg::pixel_t p);
		conv_data_pkg::result_t r;
		longint acc;
		for (int o = 0; o < conv_geom_pkg::OUT_CH; o++) begin
			acc = 0;
			for (int i = 0; i < conv_geom_pkg::IN_CH; i++) begin
				acc = acc + longint'(model_w[o*conv_geom_pkg::IN_CH + i]) * longint'(p[i]);
			end
			r[o] = acc[31:0];
		end
		return r;
	endfunction

	// Inputs change 2 ns after the edge
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("FAIL %s expected %0b actual %0b", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		assert (act == exp) else begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) tick();
		reset = 1'b0;
		model_idx = 0;
		pending.delete();
	endtask

	task automatic send_weight();
		weight_valid = 1'b1;
		weight = rand16();
		model_w[model_idx] = weight;
		model_idx = (model_idx + 1) % conv_geom_pkg::WEIGHT_NUM;
		tick();
		weight_valid = 1'b0;
	endtask

	// Full FIFO drops the pixel, so the model skips it too
	task automatic send_pixel();
		pixel_valid = 1'b1;
		pixel[0] = rand16();
		pixel[1] = rand16();
		if (!pixel_full) begin
			pending.push_back(pixel);
			accepted++;
		end
		tick();
		pixel_valid = 1'b0;
	endtask

	task automatic wait_weights_ready();
		int n;
		n = 0;
		while (!weights_ready && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (!weights_ready) begin
			$display("ERROR: %s weights_ready never rose", cur_test);
			other_errors++;
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (pending.size() != 0 && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (pending.size() != 0) begin
			$display("ERROR: %s results still missing after timeout", cur_test);
			other_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		conv_data_pkg::result_t exp;
		if (result_valid === 1'b1) begin
			results_seen++;
			if (pending.size() == 0) begin
				$display("ERROR: %s result appeared with no pixel pending", cur_test);
				other_errors++;
			end else begin
				exp = expected_result(pending.pop_front());
				assert (result === exp) else begin
					$display("FAIL %s expected %h actual %h", cur_test, exp, result);
					value_errors++;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		lcg_state = 32'd7;
		weight_valid = 1'b0;
		weight = '0;
		pixel_valid = 1'b0;
		pixel = '0;
		value_errors = 0;
		other_errors = 0;
		results_seen = 0;
		accepted = 0;
		cur_test = "reset";
		apply_reset();

		// Idle outputs, pixels wait without weights
		check_bit("reset_result_valid", 1'b0, result_valid);
		check_bit("reset_weights_ready", 1'b0, weights_ready);
		check_bit("reset_pixel_full", 1'b0, pixel_full);
		cur_test = "no_weights";
		repeat (3) send_pixel();
		repeat (6) tick();
		check_count("no_weights_results", 0, results_seen);

		// Three weights are not a set
		cur_test = "weight_load";
		repeat (3) send_weight();
		repeat (5) tick();
		check_bit("three_weights_ready", 1'b0, weights_ready);
		send_weight();
		wait_weights_ready();

		// Early pixels drain in order
		cur_test = "early_pixels";
		wait_drained();
		check_count("early_pixels_results", 3, results_seen);

		// Random stream with gaps
		cur_test = "stream";
		base = results_seen;
		for (int k = 0; k < 40; k++) begin
			send_pixel();
			gap = int'(rand16() % 16'd3);
			repeat (gap) tick();
		end
		wait_drained();
		check_count("stream_results", 40, results_seen - base);

		// Fill the pixel FIFO past its depth
		cur_test = "overflow";
		apply_reset();
		accepted = 0;
		repeat (PIXEL_DEPTH + 3) send_pixel();
		check_bit("overflow_pixel_full", 1'b1, pixel_full);
		check_count("overflow_accepted", PIXEL_DEPTH, accepted);
		base = results_seen;
		repeat (4) send_weight();
		wait_weights_ready();
		wait_drained();
		repeat (4) tick();
		check_count("overflow_results", PIXEL_DEPTH, results_seen - base);

		// New weight set, ready already high, so settle for the path latency
		cur_test = "reload";
		repeat (4) send_weight();
		repeat (6) tick();
		base = results_seen;
		repeat (10) send_pixel();
		wait_drained();
		repeat (4) tick();
		check_count("reload_results", 10, results_seen - base);

		$display("Error counts: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
